// ==== rtl/riscv_core_pkg.sv ====
`default_nettype none

package riscv_core_pkg;

  localparam int REG_ADDR_W = 5;
  localparam int INSTR_W    = 32;

  // Accepted major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  typedef struct packed {
    logic                  valid;
    logic                  regwrite;  // Low for illegal encodings and rd of x0
    alu_op_e               alu_op;
    logic                  use_imm;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
  } decode_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/riscv_core_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_core_decode #(
  parameter int XLEN = 64
) (
  input  logic                                  i_riscv_core_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_instr_valid,
  input  logic [riscv_core_pkg::INSTR_W-1:0]    i_instr,
  input  logic [XLEN-1:0]                       i_rf_rd1,
  input  logic [XLEN-1:0]                       i_rf_rd2,
  output logic [riscv_core_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [riscv_core_pkg::REG_ADDR_W-1:0] o_rs2,
  output riscv_core_pkg::decode_ctrl_t          o_ctrl,
  output logic [XLEN-1:0]                       o_rd1,
  output logic [XLEN-1:0]                       o_rd2,
  output logic [XLEN-1:0]                       o_imm
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [6:0]                   opcode;
  logic [2:0]                   funct3;
  logic [6:0]                   funct7;
  logic [11:0]                  shift_hi;  // Immediate bits above the shift amount
  logic                         legal;
  riscv_core_pkg::alu_op_e      alu_op;
  riscv_core_pkg::decode_ctrl_t ctrl_d;
  logic [XLEN-1:0]              imm_d;

  // funct3 to ALU op, alt picks SUB / SRA
  function automatic riscv_core_pkg::alu_op_e base_op(input logic [2:0] f3, input logic alt);
    riscv_core_pkg::alu_op_e op;
    op = riscv_core_pkg::ALU_ADD;
    case (f3)
      riscv_core_pkg::F3_ADD_SUB: op = alt ? riscv_core_pkg::ALU_SUB : riscv_core_pkg::ALU_ADD;
      riscv_core_pkg::F3_SLL:     op = riscv_core_pkg::ALU_SLL;
      riscv_core_pkg::F3_SLT:     op = riscv_core_pkg::ALU_SLT;
      riscv_core_pkg::F3_SLTU:    op = riscv_core_pkg::ALU_SLTU;
      riscv_core_pkg::F3_XOR:     op = riscv_core_pkg::ALU_XOR;
      riscv_core_pkg::F3_SRL_SRA: op = alt ? riscv_core_pkg::ALU_SRA : riscv_core_pkg::ALU_SRL;
      riscv_core_pkg::F3_OR:      op = riscv_core_pkg::ALU_OR;
      riscv_core_pkg::F3_AND:     op = riscv_core_pkg::ALU_AND;
      default:                    op = riscv_core_pkg::ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode   = i_instr[6:0];
  assign funct3   = i_instr[14:12];
  assign funct7   = i_instr[31:25];
  assign shift_hi = i_instr[31:20] >> SHAMT_W;

  // Register file read ports
  assign o_rs1 = i_instr[19:15];
  assign o_rs2 = i_instr[24:20];

  always_comb begin
    legal  = 1'b0;
    alu_op = riscv_core_pkg::ALU_ADD;
    case (opcode)
      riscv_core_pkg::OPC_OP: begin
        legal  = (funct7 == riscv_core_pkg::F7_BASE) ||
                 ((funct7 == riscv_core_pkg::F7_ALT) &&
                  (funct3 == riscv_core_pkg::F3_ADD_SUB || funct3 == riscv_core_pkg::F3_SRL_SRA));
        alu_op = base_op(funct3, funct7[5]);
      end
      riscv_core_pkg::OPC_OP_IMM: begin
        legal  = 1'b1;
        alu_op = base_op(funct3, 1'b0);  // No SUBI
        if (funct3 == riscv_core_pkg::F3_SLL) begin
          legal = (shift_hi == '0);
        end else if (funct3 == riscv_core_pkg::F3_SRL_SRA) begin
          // SRAI carries the same bit 30 marker as SRA
          legal  = (shift_hi == '0) || (shift_hi == (12'h400 >> SHAMT_W));
          alu_op = base_op(funct3, i_instr[30]);
        end
      end
      riscv_core_pkg::OPC_LUI: begin
        legal  = 1'b1;
        alu_op = riscv_core_pkg::ALU_PASS_B;
      end
      default: legal = 1'b0;
    endcase
  end

  // U-type shifted up by 12, otherwise I-type
  assign imm_d = (opcode == riscv_core_pkg::OPC_LUI) ? XLEN'($signed({i_instr[31:12], 12'b0}))
                                                     : XLEN'($signed(i_instr[31:20]));

  always_comb begin
    ctrl_d.valid    = i_instr_valid;
    ctrl_d.regwrite = i_instr_valid && legal && (i_instr[11:7] != '0);
    ctrl_d.alu_op   = alu_op;
    ctrl_d.use_imm  = (opcode != riscv_core_pkg::OPC_OP);
    ctrl_d.rd       = i_instr[11:7];
    ctrl_d.rs1      = i_instr[19:15];
    ctrl_d.rs2      = i_instr[24:20];
  end

  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      o_ctrl <= '0;
    end else begin
      o_ctrl <= ctrl_d;
    end
  end

  // Operand and immediate payload
  always_ff @(posedge i_riscv_core_clk) begin
    o_rd1 <= i_rf_rd1;
    o_rd2 <= i_rf_rd2;
    o_imm <= imm_d;
  end

  // x0 must read back as zero on both ports
  a_x0_reads_zero : assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    ((o_rs1 != '0) || (i_rf_rd1 == '0)) && ((o_rs2 != '0) || (i_rf_rd2 == '0)));

endmodule

`default_nettype wire

// ==== rtl/riscv_core_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_core_execute #(
  parameter int XLEN = 64
) (
  input  riscv_core_pkg::decode_ctrl_t i_ctrl,
  input  logic [XLEN-1:0]              i_rd1,
  input  logic [XLEN-1:0]              i_rd2,
  input  logic [XLEN-1:0]              i_imm,
  input  riscv_core_pkg::decode_ctrl_t i_fwd_ctrl,  // Result slot
  input  logic [XLEN-1:0]              i_fwd_data,
  output riscv_core_pkg::decode_ctrl_t o_ctrl,
  output logic [XLEN-1:0]              o_result
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic               fwd_a;
  logic               fwd_b;
  logic [XLEN-1:0]    src_a;
  logic [XLEN-1:0]    rs2_val;
  logic [XLEN-1:0]    src_b;
  logic [SHAMT_W-1:0] shamt;

  // Result slot never has regwrite set for x0
  assign fwd_a = i_fwd_ctrl.regwrite && (i_fwd_ctrl.rd == i_ctrl.rs1);
  assign fwd_b = i_fwd_ctrl.regwrite && (i_fwd_ctrl.rd == i_ctrl.rs2);

  assign src_a   = fwd_a ? i_fwd_data : i_rd1;
  assign rs2_val = fwd_b ? i_fwd_data : i_rd2;
  assign src_b   = i_ctrl.use_imm ? i_imm : rs2_val;
  assign shamt   = src_b[SHAMT_W-1:0];

  always_comb begin
    case (i_ctrl.alu_op)
      riscv_core_pkg::ALU_ADD:    o_result = src_a + src_b;
      riscv_core_pkg::ALU_SUB:    o_result = src_a - src_b;
      riscv_core_pkg::ALU_SLL:    o_result = src_a << shamt;
      riscv_core_pkg::ALU_SLT:    o_result = XLEN'($signed(src_a) < $signed(src_b));
      riscv_core_pkg::ALU_SLTU:   o_result = XLEN'(src_a < src_b);
      riscv_core_pkg::ALU_XOR:    o_result = src_a ^ src_b;
      riscv_core_pkg::ALU_SRL:    o_result = src_a >> shamt;
      riscv_core_pkg::ALU_SRA:    o_result = $signed(src_a) >>> shamt;
      riscv_core_pkg::ALU_OR:     o_result = src_a | src_b;
      riscv_core_pkg::ALU_AND:    o_result = src_a & src_b;
      riscv_core_pkg::ALU_PASS_B: o_result = src_b;
      default:                    o_result = '0;
    endcase
  end

  // Control goes on to the result slot untouched
  assign o_ctrl = i_ctrl;

endmodule

`default_nettype wire

// ==== rtl/riscv_core_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_core_writeback #(
  parameter int XLEN = 64
) (
  input  logic                                  i_riscv_core_clk,
  input  logic                                  i_rst_n,
  input  riscv_core_pkg::decode_ctrl_t          i_ctrl,
  input  logic [XLEN-1:0]                       i_result,
  input  logic [riscv_core_pkg::REG_ADDR_W-1:0] i_rs1,
  input  logic [riscv_core_pkg::REG_ADDR_W-1:0] i_rs2,
  output logic [XLEN-1:0]                       o_rf_rd1,
  output logic [XLEN-1:0]                       o_rf_rd2,
  output riscv_core_pkg::decode_ctrl_t          o_fwd_ctrl,
  output logic [XLEN-1:0]                       o_fwd_data,
  output logic                                  o_wb_valid,
  output logic [riscv_core_pkg::REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]                       o_wb_data
);

  localparam int NUM_REGS = 2 ** riscv_core_pkg::REG_ADDR_W;

  riscv_core_pkg::decode_ctrl_t ctrl_q;
  logic [XLEN-1:0]              result_q;
  logic [XLEN-1:0]              rf_mem [NUM_REGS];
  logic                         wr_en;

  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= i_ctrl;
    end
  end

  always_ff @(posedge i_riscv_core_clk) begin
    result_q <= i_result;
  end

  assign wr_en = ctrl_q.regwrite;  // Already excludes x0 and illegal ops

  // Architectural state is zero after reset, x0 is never written
  always_ff @(posedge i_riscv_core_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf_mem[i] <= '0;
      end
    end else if (wr_en) begin
      rf_mem[ctrl_q.rd] <= result_q;
    end
  end

  // Write-through so decode sees the value landing this edge
  assign o_rf_rd1 = (wr_en && (ctrl_q.rd == i_rs1)) ? result_q : rf_mem[i_rs1];
  assign o_rf_rd2 = (wr_en && (ctrl_q.rd == i_rs2)) ? result_q : rf_mem[i_rs2];

  assign o_fwd_ctrl = ctrl_q;
  assign o_fwd_data = result_q;

  assign o_wb_valid = ctrl_q.regwrite;
  assign o_wb_rd    = ctrl_q.rd;
  assign o_wb_data  = result_q;

  // Decode must have cleared regwrite for rd of x0
  a_no_x0_write : assert property (@(posedge i_riscv_core_clk) disable iff (!i_rst_n)
    wr_en |-> (ctrl_q.rd != '0));

endmodule

`default_nettype wire

// ==== rtl/riscv_core_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscv_core_top #(
  parameter int XLEN = 64
) (
  input  logic                                  i_riscv_core_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_instr_valid,
  input  logic [riscv_core_pkg::INSTR_W-1:0]    i_instr,
  output logic                                  o_wb_valid,
  output logic [riscv_core_pkg::REG_ADDR_W-1:0] o_wb_rd,
  output logic [XLEN-1:0]                       o_wb_data
);

  logic [riscv_core_pkg::REG_ADDR_W-1:0] rs1_id;
  logic [riscv_core_pkg::REG_ADDR_W-1:0] rs2_id;
  logic [XLEN-1:0]                       rf_rd1;
  logic [XLEN-1:0]                       rf_rd2;
  riscv_core_pkg::decode_ctrl_t          id_ex_ctrl;
  logic [XLEN-1:0]                       id_ex_rd1;
  logic [XLEN-1:0]                       id_ex_rd2;
  logic [XLEN-1:0]                       id_ex_imm;
  riscv_core_pkg::decode_ctrl_t          ex_ctrl;
  logic [XLEN-1:0]                       ex_result;
  riscv_core_pkg::decode_ctrl_t          fwd_ctrl;   // Result slot, back to execute
  logic [XLEN-1:0]                       fwd_data;

  riscv_core_decode #(
    .XLEN (XLEN)
  ) u_decode (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_instr_valid    (i_instr_valid),
    .i_instr          (i_instr),
    .i_rf_rd1         (rf_rd1),
    .i_rf_rd2         (rf_rd2),
    .o_rs1            (rs1_id),
    .o_rs2            (rs2_id),
    .o_ctrl           (id_ex_ctrl),
    .o_rd1            (id_ex_rd1),
    .o_rd2            (id_ex_rd2),
    .o_imm            (id_ex_imm)
  );

  riscv_core_execute #(
    .XLEN (XLEN)
  ) u_execute (
    .i_ctrl     (id_ex_ctrl),
    .i_rd1      (id_ex_rd1),
    .i_rd2      (id_ex_rd2),
    .i_imm      (id_ex_imm),
    .i_fwd_ctrl (fwd_ctrl),
    .i_fwd_data (fwd_data),
    .o_ctrl     (ex_ctrl),
    .o_result   (ex_result)
  );

  riscv_core_writeback #(
    .XLEN (XLEN)
  ) u_writeback (
    .i_riscv_core_clk (i_riscv_core_clk),
    .i_rst_n          (i_rst_n),
    .i_ctrl           (ex_ctrl),
    .i_result         (ex_result),
    .i_rs1            (rs1_id),
    .i_rs2            (rs2_id),
    .o_rf_rd1         (rf_rd1),
    .o_rf_rd2         (rf_rd2),
    .o_fwd_ctrl       (fwd_ctrl),
    .o_fwd_data       (fwd_data),
    .o_wb_valid       (o_wb_valid),
    .o_wb_rd          (o_wb_rd),
    .o_wb_data        (o_wb_data)
  );

endmodule

`default_nettype wire

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 5  // 10 ns period
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;  // First rising edge at 5 ns
  end

  always begin
    #(HALF_PERIOD_NS) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// ==== dv/tb_riscv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_riscv_core;

  localparam int XLEN      = 64;
  localparam int SHAMT_W   = $clog2(XLEN);
  localparam int NUM_INSTR = 2000;
  localparam int DRAIN_MAX = 10;

  // One expected write-back
  typedef struct packed {
    logic [4:0]      rd;
    logic [XLEN-1:0] data;
    logic [31:0]     due;  // Cycle in which the result must be on the outputs
  } wb_exp_t;

  logic            clk;
  logic            rst_n;
  logic            instr_valid;
  logic [31:0]     instr;
  logic            wb_valid;
  logic [4:0]      wb_rd;
  logic [XLEN-1:0] wb_data;

  logic [31:0]     rng_state;
  logic [31:0]     cycle;
  int unsigned     num_checks;
  int unsigned     num_errors;
  logic [XLEN-1:0] model_rf [32];
  wb_exp_t         exp_q [$];

  tb_clk_gen #(.HALF_PERIOD_NS (5)) u_clk_gen (.o_clk (clk));

  riscv_core_top #(
    .XLEN (XLEN)
  ) i_dut (
    .i_riscv_core_clk (clk),
    .i_rst_n          (rst_n),
    .i_instr_valid    (instr_valid),
    .i_instr          (instr),
    .o_wb_valid       (wb_valid),
    .o_wb_rd          (wb_rd),
    .o_wb_data        (wb_data)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
    return {{(XLEN-12){v[11]}}, v};
  endfunction

  // {alt bit, funct3} for ops 0..9: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
  function automatic logic [3:0] op_encoding(input int op);
    case (op)
      0:       return 4'b0000;
      1:       return 4'b1000;
      2:       return 4'b0001;
      3:       return 4'b0010;
      4:       return 4'b0011;
      5:       return 4'b0100;
      6:       return 4'b0101;
      7:       return 4'b1101;
      8:       return 4'b0110;
      default: return 4'b0111;
    endcase
  endfunction

  // ADDI SLTI SLTIU XORI SLLI SRLI SRAI ORI ANDI onto ALU ops
  function automatic int imm_alu_op(input int idx);
    case (idx)
      0:       return 0;
      1:       return 3;
      2:       return 4;
      3:       return 5;
      4:       return 2;
      5:       return 6;
      6:       return 7;
      7:       return 8;
      default: return 9;
    endcase
  endfunction

  function automatic logic [XLEN-1:0] alu_model(input int op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      0:       return a + b;
      1:       return a - b;
      2:       return a << b[SHAMT_W-1:0];
      3:       return {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      4:       return {{(XLEN-1){1'b0}}, (a < b)};
      5:       return a ^ b;
      6:       return a >> b[SHAMT_W-1:0];
      7:       return $signed(a) >>> b[SHAMT_W-1:0];
      8:       return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic check_outputs();
    wb_exp_t want;
    logic    due_now;
    due_now = (exp_q.size() != 0) && (exp_q[0].due == cycle);
    if (due_now) begin
      want = exp_q.pop_front();
      num_checks++;
      assert (wb_valid === 1'b1) else begin
        num_errors++;
        $display("No write-back for x%0d at %0t", want.rd, $time);
      end
      assert (wb_valid !== 1'b1 || (wb_rd === want.rd && wb_data === want.data)) else begin
        num_errors++;
        $display("MISMATCH at %0t: got x%0d = %h, expected x%0d = %h",
                 $time, wb_rd, wb_data, want.rd, want.data);
      end
    end else begin
      assert (wb_valid === 1'b0) else begin
        num_errors++;
        $display("Unexpected write-back to x%0d at %0t", wb_rd, $time);
      end
    end
  endtask

  // Outputs are stable on the falling edge, inputs change right after the check
  task automatic advance_cycle();
    @(negedge clk);
    cycle = cycle + 32'd1;
    check_outputs();
  endtask

  task automatic issue_random();
    logic [31:0]     r;
    logic [31:0]     r2;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [3:0]      enc;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] res;
    int              op;
    int              aop;
    wb_exp_t         item;
    next_rand(r);
    next_rand(r2);
    rd  = {2'b00, r[2:0]};  // x0..x7 keeps hazards frequent
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    a   = model_rf[rs1];
    res = '0;
    if (r[31:24] < 8'd13) begin  // About 5 percent illegal
      if (r[9]) begin
        instr = {r2[31:7], 7'b0001011};  // custom-0 opcode
      end else begin
        instr = {7'b0000001, rs2, rs1, r2[14:12], rd, 7'b0110011};  // M extension
      end
      rd = 5'd0;  // Retires with no write-back
    end else begin
      op = int'(r[23:10]) % 20;
      if (op < 10) begin
        enc   = op_encoding(op);
        instr = {1'b0, enc[3], 5'b0, rs2, rs1, enc[2:0], rd, 7'b0110011};
        res   = alu_model(op, a, model_rf[rs2]);
      end else if (op < 19) begin
        aop = imm_alu_op(op - 10);
        enc = op_encoding(aop);
        if (aop == 2 || aop == 6 || aop == 7) begin
          instr = {1'b0, enc[3], 4'b0, r2[5:0], rs1, enc[2:0], rd, 7'b0010011};
          res   = alu_model(aop, a, {{(XLEN-6){1'b0}}, r2[5:0]});
        end else begin
          instr = {r2[11:0], rs1, enc[2:0], rd, 7'b0010011};
          res   = alu_model(aop, a, sext12(r2[11:0]));
        end
      end else begin
        instr = {r2[31:12], rd, 7'b0110111};  // LUI
        res   = {{(XLEN-32){r2[31]}}, r2[31:12], 12'b0};
      end
    end
    instr_valid = 1'b1;
    if (rd != 5'd0) begin
      model_rf[rd] = res;
      item.rd      = rd;
      item.data    = res;
      item.due     = cycle + 32'd2;
      exp_q.push_back(item);
    end
  endtask

  initial begin
    logic [31:0] r;
    int unsigned gap;
    int unsigned drain;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    rng_state   = 32'd69029;
    cycle       = '0;
    num_checks  = 0;
    num_errors  = 0;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (4) advance_cycle();
    rst_n = 1'b1;
    repeat (3) advance_cycle();  // Quiet outputs after reset
    for (int n = 0; n < NUM_INSTR; n++) begin
      advance_cycle();
      issue_random();
      next_rand(r);
      gap = r % 32'd3;
      repeat (gap) begin
        advance_cycle();
        instr_valid = 1'b0;
        instr       = r;  // Garbage while the strobe is low
      end
    end
    advance_cycle();
    instr_valid = 1'b0;
    drain = 0;
    while (exp_q.size() != 0 && drain < DRAIN_MAX) begin
      advance_cycle();
      drain++;
    end
    if (exp_q.size() != 0) begin
      num_errors++;
      $display("Timeout: %0d expected write-backs never came out", exp_q.size());
    end
    repeat (3) advance_cycle();
    $display("Checks: %0d  Errors: %0d", num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/riscv_core_pkg.sv
rtl/riscv_core_decode.sv
rtl/riscv_core_execute.sv
rtl/riscv_core_writeback.sv
rtl/riscv_core_top.sv
dv/tb_clk_gen.sv
dv/tb_riscv_core.sv

// ==== Makefile ====
TOP := tb_riscv_core
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
